// File: filelist.f
hdl/apb_pkg.sv
hdl/mdio_pkg.sv
hdl/mdio_apb_regs.sv
hdl/mdio_frame_engine.sv
hdl/mdio_read_capture.sv
hdl/apb_mdio_top.sv
verification/mdio_frame_chk.sv
verification/tb_apb_mdio.sv

// File: hdl/apb_mdio_top.sv
`timescale 1ns/100ps
`default_nettype none

module apb_mdio_top #(
	parameter int CLK_DIV = 16
) (
	input  wire               apb,
	input  wire               rst_n,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp,
	output wire               mdc,
	output wire               mdio_o,
	output wire               mdio_oe,
	input  wire               mdio_i
);

	mdio_pkg::mdio_cmd_t    cmd;
	mdio_pkg::mdio_sample_t smp;
	mdio_pkg::mdio_status_t status;

	////////////////////////////////////////////////////////////
	// Decode, execute, result

	mdio_apb_regs u_regs (
		.apb    (apb),
		.rst_n  (rst_n),
		.req    (req),
		.rsp    (rsp),
		.status (status),
		.cmd    (cmd)
	);

	// Sets the MDC period
	mdio_frame_engine #(
		.CLK_DIV (CLK_DIV)
	) u_engine (
		.apb     (apb),
		.rst_n   (rst_n),
		.cmd     (cmd),
		.busy    (status.busy),
		.smp     (smp),
		.mdc     (mdc),
		.mdio_o  (mdio_o),
		.mdio_oe (mdio_oe)
	);

	mdio_read_capture u_capture (
		.apb    (apb),
		.rst_n  (rst_n),
		.smp    (smp),
		.mdio_i (mdio_i),
		.rdata  (status.rdata)
	);

endmodule

`default_nettype wire

// File: hdl/apb_pkg.sv
`default_nettype none

package apb_pkg;

	////////////////////////////////////////////////////////////
	// Bus transfer types

	// Request from the bus master, setup and access phase
	typedef struct packed {
		logic        sel;
		logic        enable;
		logic        write;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} apb_req_t;

	// Completer response, valid in the access phase only
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
		logic        slverr;
	} apb_rsp_t;

	////////////////////////////////////////////////////////////
	// Register offsets

	// PHY and register address, bit 15 selects write
	localparam logic [7:0] CMD_ADDR     = 8'h00;
	localparam logic [7:0] DATA_ADDR    = 8'h08;
	// Busy flag and its alias 32 bytes further up
	localparam logic [7:0] STATUS_ADDR  = 8'h40;
	localparam logic [7:0] STATUS2_ADDR = 8'h60;

endpackage

`default_nettype wire

// File: hdl/mdio_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module mdio_apb_regs (
	input  wire                   apb,
	input  wire                   rst_n,
	input  apb_pkg::apb_req_t     req,
	output apb_pkg::apb_rsp_t     rsp,
	input  mdio_pkg::mdio_status_t status,
	output mdio_pkg::mdio_cmd_t   cmd
);

	////////////////////////////////////////////////////////////
	// Access decode

	logic access;
	logic wr_access;
	logic cmd_wr;
	logic data_wr;
	logic read_start;

	// No wait states, ready whenever the access phase is seen
	assign access    = req.sel & req.enable;
	assign wr_access = access & req.write;

	// Commands are dropped outright while a frame is running
	assign cmd_wr  = wr_access && (req.addr == apb_pkg::CMD_ADDR) && !status.busy;
	assign data_wr = wr_access && (req.addr == apb_pkg::DATA_ADDR) && !status.busy;

	// Bit 15 clear kicks off a read, set only loads addresses
	assign read_start = cmd_wr && !req.wdata[15];

	////////////////////////////////////////////////////////////
	// Command registers

	logic        start_q;
	logic        write_q;
	logic [4:0]  phy_addr_q;
	logic [4:0]  reg_addr_q;
	logic [15:0] wdata_q;

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			start_q    <= 1'b0;
			write_q    <= 1'b0;
			phy_addr_q <= 5'd0;
			reg_addr_q <= 5'd0;
		end else begin
			// Strobe lasts exactly one cycle
			start_q <= read_start || data_wr;

			if (cmd_wr) begin
				phy_addr_q <= req.wdata[4:0];
				reg_addr_q <= req.wdata[12:8];
			end

			// Frame direction follows the register that fired
			if (read_start)
				write_q <= 1'b0;
			else if (data_wr)
				write_q <= 1'b1;
		end
	end

	// Write payload, only meaningful alongside a write start
	always_ff @(posedge apb) begin
		if (data_wr)
			wdata_q <= req.wdata[15:0];
	end

	assign cmd = '{
		start:    start_q,
		write:    write_q,
		phy_addr: phy_addr_q,
		reg_addr: reg_addr_q,
		wdata:    wdata_q
	};

	////////////////////////////////////////////////////////////
	// Response and read mux

	always_comb begin
		rsp.ready  = access;
		rsp.rdata  = 32'd0;
		rsp.slverr = 1'b0;

		if (access) begin
			case (req.addr)
				// Write flag reads back as zero
				apb_pkg::CMD_ADDR: begin
					if (!req.write)
						rsp.rdata = {16'd0, 3'd0, reg_addr_q, 3'd0, phy_addr_q};
				end
				// Last completed read
				apb_pkg::DATA_ADDR: begin
					if (!req.write)
						rsp.rdata = {16'd0, status.rdata};
				end
				apb_pkg::STATUS_ADDR,
				apb_pkg::STATUS2_ADDR: begin
					if (!req.write)
						rsp.rdata = {31'd0, status.busy};
				end
				// Unmapped, error for both directions
				default: rsp.slverr = 1'b1;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/mdio_frame_engine.sv
`timescale 1ns/100ps
`default_nettype none

module mdio_frame_engine #(
	parameter int CLK_DIV = 16
) (
	input  wire                        apb,
	input  wire                        rst_n,
	input  mdio_pkg::mdio_cmd_t        cmd,
	output logic                       busy,
	output mdio_pkg::mdio_sample_t     smp,
	output logic                       mdc,
	output logic                       mdio_o,
	output logic                       mdio_oe
);

	////////////////////////////////////////////////////////////
	// Counter limits

	localparam int DIV_W = $clog2(CLK_DIV);

	// Last cycle of a bit, MDC falls after it
	localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(CLK_DIV - 1);
	// Last low cycle, MDC rises after it
	localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(CLK_DIV / 2 - 1);

	localparam logic [5:0] BIT_LAST = 6'(mdio_pkg::FRAME_BITS - 1);
	// Station keeps the line up to the bit before TA
	localparam logic [5:0] DRIVE_LAST = 6'(mdio_pkg::PREAMBLE_BITS + 13);
	// First of the 16 data bit times
	localparam logic [5:0] DATA_FIRST = 6'(mdio_pkg::FRAME_BITS - 16);

	logic [DIV_W-1:0] div_cnt;
	logic [5:0]       bit_cnt;
	logic             wr_frame;
	logic [63:0]      shift_q;
	logic [63:0]      frame;
	logic             bit_end;
	logic             launch;

	assign launch  = !busy && cmd.start;
	assign bit_end = busy && (div_cnt == DIV_LAST);

	////////////////////////////////////////////////////////////
	// Frame assembly

	// Preamble, ST, OP, addresses, TA, data in wire order
	always_comb begin
		if (cmd.write)
			frame = {{mdio_pkg::PREAMBLE_BITS{1'b1}}, mdio_pkg::ST_BITS,
				mdio_pkg::OP_WRITE, cmd.phy_addr, cmd.reg_addr,
				mdio_pkg::TA_WRITE, cmd.wdata};
		else
			// TA and data are released anyway, filler is idle high
			frame = {{mdio_pkg::PREAMBLE_BITS{1'b1}}, mdio_pkg::ST_BITS,
				mdio_pkg::OP_READ, cmd.phy_addr, cmd.reg_addr, 2'b11, 16'hffff};
	end

	// MSB goes out first, left shift at each MDC fall
	always_ff @(posedge apb) begin
		if (launch)
			shift_q <= frame;
		else if (bit_end)
			shift_q <= {shift_q[62:0], 1'b1};
	end

	////////////////////////////////////////////////////////////
	// Sequencer and pins

	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			div_cnt  <= '0;
			bit_cnt  <= 6'd0;
			wr_frame <= 1'b0;
			mdc      <= 1'b0;
			mdio_o   <= 1'b1;
			mdio_oe  <= 1'b0;
		end else if (!busy) begin
			if (cmd.start) begin
				busy     <= 1'b1;
				div_cnt  <= '0;
				bit_cnt  <= 6'd0;
				wr_frame <= cmd.write;
				// First preamble bit, MDC still low
				mdio_o   <= frame[63];
				mdio_oe  <= 1'b1;
			end
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			mdc     <= 1'b0;
			if (bit_cnt == BIT_LAST) begin
				// Frame over, back to idle
				busy    <= 1'b0;
				mdio_o  <= 1'b1;
				mdio_oe <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 6'd1;
				mdio_o  <= shift_q[62];
				// Reads let go of the line from TA onwards
				mdio_oe <= wr_frame || (bit_cnt < DRIVE_LAST);
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
			if (div_cnt == HALF_LAST)
				mdc <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Capture timing

	// Same clock edge as the MDC rise
	assign smp.sample   = busy && (div_cnt == HALF_LAST);
	assign smp.data_bit = !wr_frame && (bit_cnt >= DATA_FIRST);
	// Last busy cycle of a read
	assign smp.done     = bit_end && !wr_frame && (bit_cnt == BIT_LAST);

endmodule

`default_nettype wire

// File: hdl/mdio_pkg.sv
`default_nettype none

package mdio_pkg;

	////////////////////////////////////////////////////////////
	// Stage to stage links

	// Decode to execute, fields valid while start is high
	typedef struct packed {
		logic        start;
		logic        write;
		logic [4:0]  phy_addr;
		logic [4:0]  reg_addr;
		logic [15:0] wdata;
	} mdio_cmd_t;

	// Execute to result
	typedef struct packed {
		logic sample;
		logic data_bit;
		logic done;
	} mdio_sample_t;

	// Back to the register block
	typedef struct packed {
		logic        busy;
		logic [15:0] rdata;
	} mdio_status_t;

	////////////////////////////////////////////////////////////
	// Clause 22 frame fields

	localparam logic [1:0] ST_BITS  = 2'b01;
	localparam logic [1:0] OP_READ  = 2'b10;
	localparam logic [1:0] OP_WRITE = 2'b01;
	// Turnaround as driven by the station on writes
	localparam logic [1:0] TA_WRITE = 2'b10;

	localparam int PREAMBLE_BITS = 32;
	localparam int FRAME_BITS    = 64;

endpackage

`default_nettype wire

// File: hdl/mdio_read_capture.sv
`timescale 1ns/100ps
`default_nettype none

module mdio_read_capture (
	input  wire                    apb,
	input  wire                    rst_n,
	input  mdio_pkg::mdio_sample_t smp,
	input  wire                    mdio_i,
	output logic [15:0]            rdata
);

	////////////////////////////////////////////////////////////
	// Data bit shifter

	logic [15:0] shift_q;

	// PHY drives MSB first, so shift in from the bottom
	always_ff @(posedge apb) begin
		if (smp.sample && smp.data_bit)
			shift_q <= {shift_q[14:0], mdio_i};
	end

	////////////////////////////////////////////////////////////
	// Held result

	// Only updated once all 16 bits are in
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			rdata <= 16'd0;
		else if (smp.done)
			rdata <= shift_q;
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MDIO controller testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_apb_mdio \
	-f filelist.f \
	--Mdir obj_dir -o tb_apb_mdio
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_apb_mdio
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: verification/mdio_frame_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mdio_frame_chk #(
	parameter int CLK_DIV = 16
) (
	input  wire                 apb,
	input  wire                 rst_n,
	input  mdio_pkg::mdio_cmd_t cmd,
	input  wire                 busy,
	input  wire                 wr_frame,
	input  wire [5:0]           bit_cnt,
	input  wire                 mdio_oe,
	input  wire                 mdc
);

	////////////////////////////////////////////////////////////
	// Frame length bookkeeping

	localparam int FRAME_CYC = mdio_pkg::FRAME_BITS * CLK_DIV;
	// First TA bit, line released from here in reads
	localparam logic [5:0] TA_FIRST = 6'(mdio_pkg::PREAMBLE_BITS + 14);

	int busy_len;

	// Busy cycles of the current frame
	always_ff @(posedge apb or negedge rst_n) begin
		if (!rst_n)
			busy_len <= 0;
		else if (busy)
			busy_len <= busy_len + 1;
		else
			busy_len <= 0;
	end

	////////////////////////////////////////////////////////////
	// Frame rules

	a_frame_len: assert property (@(posedge apb) disable iff (!rst_n)
		$fell(busy) |-> (busy_len == FRAME_CYC))
		else $error("busy lasted %0d cycles instead of %0d", busy_len, FRAME_CYC);

	// Never longer than one frame either
	a_frame_max: assert property (@(posedge apb) disable iff (!rst_n)
		busy |-> (busy_len < FRAME_CYC))
		else $error("busy held past %0d cycles", FRAME_CYC);

	a_read_release: assert property (@(posedge apb) disable iff (!rst_n)
		(busy && !wr_frame && (bit_cnt >= TA_FIRST)) |-> !mdio_oe)
		else $error("mdio_oe high during TA or data of a read frame");

	a_write_drive: assert property (@(posedge apb) disable iff (!rst_n)
		(busy && wr_frame) |-> mdio_oe)
		else $error("mdio_oe low during a write frame");

	a_no_start_busy: assert property (@(posedge apb) disable iff (!rst_n)
		cmd.start |-> !busy)
		else $error("start strobe while a frame is running");

	// MDC stays parked low between frames
	a_mdc_idle: assert property (@(posedge apb) disable iff (!rst_n)
		!busy |-> !mdc)
		else $error("mdc high while idle");

endmodule

`default_nettype wire

// File: verification/tb_apb_mdio.sv
`timescale 1ns/100ps
`default_nettype none

module tb_apb_mdio;

	localparam int CLK_DIV    = 8;
	localparam int PERIOD     = 100;
	localparam int POLL_LIMIT = 400;
	localparam int WATCHDOG   = 50000;
	localparam logic [4:0] PHY_ADDR = 5'd5;

	logic              apb;
	logic              rst_n;
	apb_pkg::apb_req_t req;
	apb_pkg::apb_rsp_t rsp;
	wire               mdc;
	wire               mdio_o;
	wire               mdio_oe;
	wire               mdio_i;

	// PHY side of the shared line
	logic              phy_oe = 1'b0;
	logic              phy_bit = 1'b1;
	logic [15:0]       phy_regs [32];
	logic [63:0]       frame_sh = '0;
	int                rise_cnt = 0;
	logic [1:0]        m_op = 2'b00;
	logic [4:0]        m_phy = 5'd0;
	logic [4:0]        m_reg = 5'd0;

	apb_mdio_top #(
		.CLK_DIV (CLK_DIV)
	) i_dut (
		.apb     (apb),
		.rst_n   (rst_n),
		.req     (req),
		.rsp     (rsp),
		.mdc     (mdc),
		.mdio_o  (mdio_o),
		.mdio_oe (mdio_oe),
		.mdio_i  (mdio_i)
	);

	bind mdio_frame_engine mdio_frame_chk #(.CLK_DIV(CLK_DIV)) i_frame_chk (
		.apb      (apb),
		.rst_n    (rst_n),
		.cmd      (cmd),
		.busy     (busy),
		.wr_frame (wr_frame),
		.bit_cnt  (bit_cnt),
		.mdio_oe  (mdio_oe),
		.mdc      (mdc)
	);

	// Pull-up when nobody drives
	assign mdio_i = mdio_oe ? mdio_o : (phy_oe ? phy_bit : 1'b1);

	initial begin
		apb = 1'b0;
		forever #(PERIOD / 2) apb = ~apb;
	end

	////////////////////////////////////////////////////////////
	// Reporting helpers

	task automatic fail_run();
		$display("Testbench failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic expect_eq(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			fail_run();
		end
	endtask

	// Register layout of CMD_ADDR
	function automatic logic [31:0] cmd_word(input logic wr, input logic [4:0] reg_a,
		input logic [4:0] phy_a);
		return {16'd0, wr, 2'd0, reg_a, 3'd0, phy_a};
	endfunction

	////////////////////////////////////////////////////////////
	// APB access tasks

	// Setup, access, then back to idle
	task automatic transfer(input logic wr, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge apb);
		req.sel    = 1'b1;
		req.enable = 1'b0;
		req.write  = wr;
		req.addr   = addr;
		req.wdata  = wdata;
		@(negedge apb);
		req.enable = 1'b1;
		// Mid access phase, response is settled
		#(PERIOD / 4);
		expect_eq("pready", 32'(rsp.ready), 32'd1);
		rdata = rsp.rdata;
		err   = rsp.slverr;
		@(negedge apb);
		req = '0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		transfer(1'b1, addr, data, rd, err);
		expect_eq("pslverr", 32'(err), 32'd0);
	endtask

	task automatic check_read(input string name, input logic [7:0] addr,
		input logic [31:0] exp);
		logic [31:0] rd;
		logic        err;
		transfer(1'b0, addr, 32'd0, rd, err);
		expect_eq("pslverr", 32'(err), 32'd0);
		expect_eq(name, rd, exp);
	endtask

	task automatic check_error(input logic wr, input logic [7:0] addr);
		logic [31:0] rd;
		logic        err;
		transfer(wr, addr, 32'hffff_ffff, rd, err);
		expect_eq("pslverr", 32'(err), 32'd1);
	endtask

	// Poll STATUS until the frame is over
	task automatic wait_idle();
		logic [31:0] rd;
		logic        err;
		int          polls;
		polls = 0;
		transfer(1'b0, apb_pkg::STATUS_ADDR, 32'd0, rd, err);
		while (rd[0] && polls < POLL_LIMIT) begin
			transfer(1'b0, apb_pkg::STATUS_ADDR, 32'd0, rd, err);
			polls++;
		end
		if (rd[0]) begin
			$display("timeout: busy still set after %0d status polls", polls);
			fail_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// PHY register model

	initial begin
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'(i);
	end

	always @(posedge mdc or negedge mdc) begin
		if (mdc) begin
			frame_sh = {frame_sh[62:0], mdio_i};
			rise_cnt = rise_cnt + 1;
			// Header complete after the register address
			if (rise_cnt == mdio_pkg::PREAMBLE_BITS + 14) begin
				expect_eq("st", 32'(frame_sh[13:12]), 32'(mdio_pkg::ST_BITS));
				m_op  = frame_sh[11:10];
				m_phy = frame_sh[9:5];
				m_reg = frame_sh[4:0];
			end else if (rise_cnt == mdio_pkg::FRAME_BITS && m_op == mdio_pkg::OP_WRITE) begin
				expect_eq("ta", 32'(frame_sh[17:16]), 32'(mdio_pkg::TA_WRITE));
				if (m_phy == PHY_ADDR)
					phy_regs[m_reg] = frame_sh[15:0];
			end
		end else if (rise_cnt == mdio_pkg::FRAME_BITS) begin
			// End of frame, let go of the line
			rise_cnt = 0;
			phy_oe   = 1'b0;
			m_op     = 2'b00;
		end else if (m_op == mdio_pkg::OP_READ && m_phy == PHY_ADDR && rise_cnt >= 47) begin
			phy_oe = 1'b1;
			// Second TA bit is a zero, then data MSB first
			if (rise_cnt == 47)
				phy_bit = 1'b0;
			else
				phy_bit = phy_regs[m_reg][63 - rise_cnt];
		end
	end

	initial begin
		repeat (WATCHDOG) @(posedge apb);
		$display("timeout: simulation ran past %0d cycles", WATCHDOG);
		fail_run();
	end

	////////////////////////////////////////////////////////////
	// Stimulus

	initial begin
		integer      seed;
		logic [4:0]  r;
		logic [15:0] v;
		logic [15:0] exp;
		seed  = 32'hc529;
		req   = '0;
		rst_n = 1'b0;
		repeat (16) @(negedge apb);
		rst_n = 1'b1;

		// Reset values
		check_read("cmd_addr", apb_pkg::CMD_ADDR, 32'd0);
		check_read("data", apb_pkg::DATA_ADDR, 32'd0);
		check_read("status", apb_pkg::STATUS_ADDR, 32'd0);
		check_read("status2", apb_pkg::STATUS2_ADDR, 32'd0);

		// Register 3 holds its own index
		write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd3, PHY_ADDR));
		wait_idle();
		check_read("data", apb_pkg::DATA_ADDR, 32'd3);

		// Random write then read back
		for (int n = 0; n < 3; n++) begin
			r = 5'($random(seed));
			v = 16'($random(seed));
			write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b1, r, PHY_ADDR));
			// Write flag never reads back
			check_read("cmd_addr", apb_pkg::CMD_ADDR, cmd_word(1'b0, r, PHY_ADDR));
			write_reg(apb_pkg::DATA_ADDR, 32'(v));
			wait_idle();
			expect_eq("phy_regs", 32'(phy_regs[r]), 32'(v));
			write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b0, r, PHY_ADDR));
			wait_idle();
			check_read("data", apb_pkg::DATA_ADDR, 32'(v));
		end

		// Address readback and status alias while busy
		exp = phy_regs[9];
		write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd9, PHY_ADDR));
		check_read("cmd_addr", apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd9, PHY_ADDR));
		check_read("status", apb_pkg::STATUS_ADDR, 32'd1);
		check_read("status2", apb_pkg::STATUS2_ADDR, 32'd1);
		wait_idle();
		check_read("status2", apb_pkg::STATUS2_ADDR, 32'd0);
		check_read("data", apb_pkg::DATA_ADDR, 32'(exp));

		// Unmapped offsets
		check_error(1'b0, 8'h10);
		check_error(1'b1, 8'h10);
		check_error(1'b0, 8'h44);
		check_error(1'b1, 8'h44);

		// Commands during a frame are dropped
		exp = phy_regs[7];
		write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd7, PHY_ADDR));
		write_reg(apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd20, 5'd2));
		write_reg(apb_pkg::DATA_ADDR, 32'h1234);
		check_read("cmd_addr", apb_pkg::CMD_ADDR, cmd_word(1'b0, 5'd7, PHY_ADDR));
		wait_idle();
		check_read("data", apb_pkg::DATA_ADDR, 32'(exp));
		expect_eq("phy_regs", 32'(phy_regs[7]), 32'(exp));

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire
